/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_rhs_array
FILELIST  = tb.f
PASS_MSG  = ** PASS **

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir

/* tb.f */
verilog/rhs_array_pkg.sv
verilog/rhs_cmd_pkg.sv
verilog/rhs_sequencer.sv
verilog/rhs_spi_lane.sv
verilog/rhs_sample_gather.sv
verilog/rhs_array_top.sv
verification/rhs_chip_model.sv
verification/tb_rhs_array.sv

/* verification/rhs_chip_model.sv */
`timescale 1ns/10ps

module rhs_chip_model #(
    parameter int LANE = 0
) (
    input  logic                clk,
    input  logic                cs,
    input  logic                sclk,
    input  logic                mosi,
    input  logic [3:0]          offset,
    output logic                miso,
    output logic [63:0][31:0]   log_words,
    output int                  log_count
);

    logic        cs_q = 1'b1;
    logic        sclk_q = 1'b0;
    logic [31:0] rx_sr = '0;
    logic [31:0] resp = '0;
    int          rx_bits = 0;
    int          tx_idx = -1;
    int          src_idx;
    logic        miso_raw = 1'b0;       // undelayed chip output
    logic [14:0] dly = '0;              // cable and chip delay line

    initial begin
        log_words = '0;
        log_count = 0;
    end

    // reply to one received command word
    function automatic logic [31:0] answer(input logic [31:0] w);
        logic [31:0] r;
        r = '0;
        if (w[31:30] == 2'b00) begin
            r[15:0] = 16'(LANE * 256 + w[21:16] * 7 + 1);
        end else if (w[31:30] == 2'b11 && w[23:16] == 8'hFF) begin
            r[15:0] = 16'h0020;         // chip id
        end
        return r;
    endfunction

    assign miso = (offset == 4'd0) ? miso_raw : dly[offset - 4'd1];

    always @(posedge clk) begin
        cs_q <= cs;
        sclk_q <= sclk;
        dly <= {dly[13:0], miso_raw};
        if (!cs && cs_q) begin
            // frame start, answer the command of two frames back
            if (log_count >= 2) begin
                src_idx = (log_count - 2) % 64;
                resp = answer(log_words[src_idx]);
            end else begin
                resp = '0;
            end
            miso_raw <= resp[31];
            tx_idx <= 30;
            rx_bits <= 0;
        end else if (!cs) begin
            if (sclk && !sclk_q) begin          // rising sclk, take mosi
                rx_sr <= {rx_sr[30:0], mosi};
                rx_bits <= rx_bits + 1;
                if (rx_bits == 31) begin
                    log_words[log_count % 64] <= {rx_sr[30:0], mosi};
                    log_count <= log_count + 1;
                end
            end
            if (!sclk && sclk_q && tx_idx >= 0) begin   // falling sclk, next bit
                miso_raw <= resp[tx_idx];
                tx_idx <= tx_idx - 1;
            end
        end
    end

endmodule

/* verification/tb_rhs_array.sv */
`timescale 1ns/10ps

module tb_rhs_array;

    import rhs_array_pkg::*;

    localparam int NUM_LANES = 4;
    localparam int TIMEOUT = 20000;

    // address and data of the register writes, in frame order
    localparam logic [23:0] CFG_PAIRS [0:16] = '{
        24'h20_0000, 24'h21_0000, 24'h26_FFFF,
        24'h00_0112, 24'h01_051A, 24'h02_0000, 24'h03_0000,
        24'h04_0016, 24'h05_0017, 24'h06_00A8, 24'h07_000A,
        24'h08_FFFF, 24'h0A_0000, 24'h0C_FFFF,
        24'h2A_0000, 24'h2E_0000, 24'h30_0000
    };

    logic                               clk = 1'b0;
    logic                               rstn;
    logic                               config_start;
    logic                               record_start;
    logic [NUM_LANES-1:0][3:0]          offsets;
    logic [NUM_LANES-1:0]               miso;
    logic                               busy;
    logic                               done;
    logic                               cs;
    logic                               sclk;
    logic [NUM_LANES-1:0]               mosi;
    sample_t [NUM_LANES-1:0][CHANNELS_PER_CHIP-1:0] data_out;
    sample_t [NUM_LANES-1:0]            chip_id;
    logic [63:0][31:0]                  log_words [NUM_LANES];
    int                                 log_count [NUM_LANES];
    int                                 errors;
    logic [31:0]                        seed;
    logic [31:0]                        rnd;
    logic [31:0]                        id_word;

    always #4 clk = ~clk;

    rhs_array_top #(
        .NUM_LANES (NUM_LANES),
        .OFFSET_W  (4)
    ) u_rhs_array_top (
        .clk               (clk),
        .rstn              (rstn),
        .config_start      (config_start),
        .record_start      (record_start),
        .oversample_offset (offsets),
        .miso              (miso),
        .busy              (busy),
        .done              (done),
        .cs                (cs),
        .sclk              (sclk),
        .mosi              (mosi),
        .data_out          (data_out),
        .chip_id           (chip_id)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_chip
        rhs_chip_model #(
            .LANE (i)
        ) u_rhs_chip_model (
            .clk       (clk),
            .cs        (cs),
            .sclk      (sclk),
            .mosi      (mosi[i]),
            .offset    (offsets[i]),
            .miso      (miso[i]),
            .log_words (log_words[i]),
            .log_count (log_count[i])
        );
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    function automatic logic [31:0] config_word(input int k);
        logic [23:0] pair;
        if (k == 3) begin
            return 32'h6A00_0000;       // clear calibration
        end
        if (k >= 18) begin
            return 32'hE0FF_0000;       // read reg 255 with U set
        end
        pair = (k < 3) ? CFG_PAIRS[k] : CFG_PAIRS[k-1];
        return {8'h80, pair};
    endfunction

    function automatic logic [31:0] record_word(input int k);
        if (k < 16) begin
            return 32'h0400_0000 | (32'(k) << 16);     // convert with H set
        end
        return 32'hC0FF_0000;
    endfunction

    function automatic logic [31:0] reply_word(input logic [31:0] w, input int lane);
        logic [31:0] r;
        r = '0;
        if (w[31:30] == 2'b00) begin
            r[15:0] = 16'(lane * 256 + w[21:16] * 7 + 1);
        end else if (w[31:30] == 2'b11 && w[23:16] == 8'hFF) begin
            r[15:0] = 16'h0020;
        end
        return r;
    endfunction

    task automatic pulse(input bit is_config);
        config_start = is_config;
        record_start = !is_config;
        @(negedge clk);
        config_start = 1'b0;
        record_start = 1'b0;
    endtask

    task automatic wait_done(input string name);
        int cyc;
        cyc = 0;
        while (!done && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!done) begin
            $display("timeout: done never came during %s", name);
            errors++;
        end else begin
            check_value({name, " busy with done"}, 32'd1, 32'(busy));
            @(negedge clk);
            check_value({name, " done width"}, 32'd0, 32'(done));
            check_value({name, " busy after done"}, 32'd0, 32'(busy));
        end
    endtask

    initial begin
        errors = 0;
        seed = 32'hf015_2cff;
        rstn = 1'b0;
        config_start = 1'b0;
        record_start = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            rnd = $random(seed);
            offsets[l] = 4'(rnd % 16);
        end
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_value("reset cs", 32'd1, 32'(cs));
        check_value("reset sclk", 32'd0, 32'(sclk));
        check_value("reset busy", 32'd0, 32'(busy));
        check_value("reset done", 32'd0, 32'(done));
        check_value("reset mosi", 32'd0, 32'(mosi));

        pulse(1'b1);
        wait_done("config");
        // frame 19 carries the reply to frame 17
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int k = 0; k < 20; k++) begin
                check_value($sformatf("config word %0d lane %0d", k, l),
                            config_word(k), log_words[l][k]);
            end
            id_word = reply_word(config_word(17), l);
            check_value($sformatf("chip_id lane %0d", l), {16'h0, id_word[15:0]},
                        {16'h0, chip_id[l]});
        end

        pulse(1'b0);
        repeat (100) @(negedge clk);
        check_value("busy mid record", 32'd1, 32'(busy));
        pulse(1'b0);                    // ignored while busy
        wait_done("record");
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int c = 0; c < CHANNELS_PER_CHIP; c++) begin
                check_value($sformatf("data_out lane %0d ch %0d", l, c),
                            32'(l * 256 + c * 7 + 1), {16'h0, data_out[l][c]});
            end
            for (int k = 0; k < 18; k++) begin
                check_value($sformatf("record word %0d lane %0d", k, l),
                            record_word(k), log_words[l][20+k]);
            end
        end
        repeat (400) @(negedge clk);
        for (int l = 0; l < NUM_LANES; l++) begin
            check_value($sformatf("word count lane %0d", l), 32'd38, 32'(log_count[l]));
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verilog/rhs_array_pkg.sv */
package rhs_array_pkg;

    localparam int CHANNELS_PER_CHIP = 16;
    localparam int SAMPLE_W = 16;       // adc result width
    localparam int WORD_W = 32;         // one spi frame word
    localparam int FRAME_IDX_W = 5;

    localparam int BIT_CYCLES = 4;      // sclk low half, high half
    localparam int CS_GAP_CYCLES = 20;  // cs high, load cycle included
    localparam int FRAME_CYCLES = WORD_W * BIT_CYCLES + CS_GAP_CYCLES;

    typedef logic [SAMPLE_W-1:0] sample_t;

    typedef enum logic {
        MODE_CONFIG = 1'b0,
        MODE_RECORD = 1'b1
    } rhs_mode_e;

    typedef struct packed {
        logic cs;       // active low chip select
        logic sclk;
        logic load;     // first cycle of a frame
        logic shift;    // start of low phase, next mosi bit
        logic sample;   // rising sclk
    } spi_tick_t;

    typedef struct packed {
        rhs_mode_e mode;
        logic [FRAME_IDX_W-1:0] frame;
    } frame_info_t;

endpackage

/* verilog/rhs_array_top.sv */
`timescale 1ns/10ps

module rhs_array_top #(
    parameter int NUM_LANES = 4,
    parameter int OFFSET_W = 4
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                config_start,
    input  logic                                record_start,
    input  logic [NUM_LANES-1:0][OFFSET_W-1:0]  oversample_offset,
    input  logic [NUM_LANES-1:0]                miso,
    output logic                                busy,
    output logic                                done,
    output logic                                cs,
    output logic                                sclk,
    output logic [NUM_LANES-1:0]                mosi,
    output rhs_array_pkg::sample_t [NUM_LANES-1:0][rhs_array_pkg::CHANNELS_PER_CHIP-1:0] data_out,
    output rhs_array_pkg::sample_t [NUM_LANES-1:0] chip_id
);

    import rhs_array_pkg::*;
    import rhs_cmd_pkg::*;

    spi_tick_t                          tick;
    rhs_cmd_u                           cmd;
    frame_info_t                        info;
    logic [NUM_LANES-1:0][WORD_W-1:0]   rx;
    logic [NUM_LANES-1:0]               rx_valid;

    assign cs = tick.cs;        // shared by every lane
    assign sclk = tick.sclk;

    rhs_sequencer u_rhs_sequencer (
        .clk          (clk),
        .rstn         (rstn),
        .config_start (config_start),
        .record_start (record_start),
        .tick         (tick),
        .cmd          (cmd),
        .info         (info),
        .busy         (busy),
        .done         (done)
    );

    // all lanes send the same word, each with its own miso offset
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        rhs_spi_lane #(
            .OFFSET_W (OFFSET_W)
        ) u_rhs_spi_lane (
            .clk      (clk),
            .rstn     (rstn),
            .tick     (tick),
            .cmd      (cmd),
            .offset   (oversample_offset[l]),
            .miso     (miso[l]),
            .mosi     (mosi[l]),
            .rx       (rx[l]),
            .rx_valid (rx_valid[l])
        );
    end

    rhs_sample_gather #(
        .NUM_LANES (NUM_LANES)
    ) u_rhs_sample_gather (
        .clk      (clk),
        .rstn     (rstn),
        .info     (info),
        .rx       (rx),
        .rx_valid (rx_valid),
        .data_out (data_out),
        .chip_id  (chip_id)
    );

endmodule

/* verilog/rhs_cmd_pkg.sv */
package rhs_cmd_pkg;

    typedef enum logic [1:0] {
        OP_CONVERT = 2'b00,
        OP_WRITE   = 2'b10,
        OP_READ    = 2'b11
    } rhs_opcode_e;

    // register access view
    typedef struct packed {
        rhs_opcode_e opcode;
        logic u;                // latch triggered registers
        logic m;                // clear compliance monitor
        logic [3:0] zero;
        logic [7:0] addr;
        logic [15:0] data;
    } rhs_reg_cmd_t;

    // adc convert view
    typedef struct packed {
        rhs_opcode_e opcode;
        logic u;
        logic m;
        logic d;                // dc amp low gain result
        logic h;                // adc offset removal
        logic [3:0] zero;
        logic [5:0] channel;
        logic [15:0] pad;
    } rhs_conv_cmd_t;

    typedef union packed {
        rhs_reg_cmd_t reg_cmd;
        rhs_conv_cmd_t conv_cmd;
    } rhs_cmd_u;

    localparam logic [31:0] CLEAR_CAL_WORD = 32'h6A00_0000;
    localparam logic [7:0] CHIP_ID_REG = 8'd255;    // reads back 32

    localparam int CONFIG_FRAMES = 20;
    localparam int RECORD_FRAMES = 18;
    localparam int CONVERT_DELAY = 2;   // result comes back two frames late

    localparam int CONFIG_WRITES = 17;
    localparam int CLEAR_CAL_FRAME = 3;

    typedef struct packed {
        logic [7:0] addr;
        logic [15:0] data;
    } cfg_entry_t;

    // register writes in frame order, clear calibration slots in at frame 3
    localparam cfg_entry_t CONFIG_TABLE [0:CONFIG_WRITES-1] = '{
        '{8'd32, 16'h0000},     // stim enable a off
        '{8'd33, 16'h0000},     // stim enable b off
        '{8'd38, 16'hFFFF},     // all dc amps powered
        '{8'd0,  16'h0112},     // adc buffer and mux bias
        '{8'd1,  16'h051A},     // twos complement, aux outputs
        '{8'd2,  16'h0000},     // impedance check off
        '{8'd3,  16'h0000},     // impedance dac off
        '{8'd4,  16'h0016},     // upper bandwidth rh1
        '{8'd5,  16'h0017},     // upper bandwidth rh2
        '{8'd6,  16'h00A8},     // lower bandwidth rl a
        '{8'd7,  16'h000A},     // lower bandwidth rl b
        '{8'd8,  16'hFFFF},     // ac amps on
        '{8'd10, 16'h0000},     // fast settle released
        '{8'd12, 16'hFFFF},     // every amp on rl a
        '{8'd42, 16'h0000},     // stimulators off
        '{8'd46, 16'h0000},     // charge recovery switch open
        '{8'd48, 16'h0000}      // recovery dac disconnected
    };

endpackage

/* verilog/rhs_sample_gather.sv */
`timescale 1ns/10ps

module rhs_sample_gather #(
    parameter int NUM_LANES = 4
) (
    input  logic                                            clk,
    input  logic                                            rstn,
    input  rhs_array_pkg::frame_info_t                      info,
    input  logic [NUM_LANES-1:0][rhs_array_pkg::WORD_W-1:0] rx,
    input  logic [NUM_LANES-1:0]                            rx_valid,
    output rhs_array_pkg::sample_t [NUM_LANES-1:0][rhs_array_pkg::CHANNELS_PER_CHIP-1:0] data_out,
    output rhs_array_pkg::sample_t [NUM_LANES-1:0]          chip_id
);

    import rhs_array_pkg::*;
    import rhs_cmd_pkg::*;

    localparam int CHAN_W = $clog2(CHANNELS_PER_CHIP);

    logic                   rec_slot;   // frame carries a conversion result
    logic                   id_slot;    // last config read, holds the chip id
    logic [FRAME_IDX_W-1:0] frame_rel;
    logic [CHAN_W-1:0]      chan;

    always_comb begin
        rec_slot = (info.mode == MODE_RECORD)
                   && (info.frame >= FRAME_IDX_W'(CONVERT_DELAY));
        id_slot = (info.mode == MODE_CONFIG)
                  && (info.frame == FRAME_IDX_W'(CONFIG_FRAMES - 1));
        frame_rel = info.frame - FRAME_IDX_W'(CONVERT_DELAY);  // frame k answers k-2
        chan = frame_rel[CHAN_W-1:0];
    end

    // each lane writes on its own rx_valid, the offsets differ
    always_ff @(posedge clk) begin
        if (!rstn) begin
            data_out <= '0;
            chip_id <= '0;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (rx_valid[l]) begin
                    if (rec_slot) begin
                        data_out[l][chan] <= rx[l][SAMPLE_W-1:0];
                    end
                    if (id_slot) begin
                        chip_id[l] <= rx[l][SAMPLE_W-1:0];
                    end
                end
            end
        end
    end

endmodule

/* verilog/rhs_sequencer.sv */
`timescale 1ns/10ps

module rhs_sequencer (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        config_start,
    input  logic                        record_start,
    output rhs_array_pkg::spi_tick_t    tick,
    output rhs_cmd_pkg::rhs_cmd_u       cmd,
    output rhs_array_pkg::frame_info_t  info,
    output logic                        busy,
    output logic                        done
);

    import rhs_array_pkg::*;
    import rhs_cmd_pkg::*;

    localparam int CYC_W = $clog2(FRAME_CYCLES);
    localparam int PHASE_W = $clog2(BIT_CYCLES);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FRAME,
        S_DONE
    } state_e;

    state_e                 state;
    rhs_mode_e              mode;
    logic [FRAME_IDX_W-1:0] frame_idx;
    logic [FRAME_IDX_W-1:0] last_frame;
    logic [FRAME_IDX_W-1:0] tbl_idx;
    logic [CYC_W-1:0]       cyc;        // cycle within the frame
    logic [CYC_W-1:0]       pos;        // cycle within the cs low window
    logic [PHASE_W-1:0]     phase;      // cycle within one spi bit
    logic                   frame_start;
    logic                   in_word;
    rhs_cmd_u               cmd_next;

    assign busy = (state != S_IDLE) || done;    // covers the done cycle too

    always_comb begin
        last_frame = (mode == MODE_CONFIG) ? FRAME_IDX_W'(CONFIG_FRAMES - 1)
                                           : FRAME_IDX_W'(RECORD_FRAMES - 1);
        frame_start = (state == S_FRAME) && (cyc == '0);
        in_word = (state == S_FRAME) && (cyc >= CYC_W'(1))
                  && (cyc <= CYC_W'(WORD_W * BIT_CYCLES));
        pos = cyc - CYC_W'(1);
        phase = PHASE_W'(pos % BIT_CYCLES);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_IDLE;
            mode <= MODE_CONFIG;
            frame_idx <= '0;
            cyc <= '0;
            done <= 1'b0;
        end else begin
            done <= (state == S_DONE);
            case (state)
                S_IDLE: begin
                    if (!busy && (config_start || record_start)) begin
                        mode <= config_start ? MODE_CONFIG : MODE_RECORD;  // config wins
                        frame_idx <= '0;
                        cyc <= '0;
                        state <= S_FRAME;
                    end
                end
                S_FRAME: begin
                    if (cyc == CYC_W'(FRAME_CYCLES - 1)) begin
                        cyc <= '0;
                        if (frame_idx == last_frame) begin
                            state <= S_DONE;
                        end else begin
                            frame_idx <= frame_idx + 1'b1;
                        end
                    end else begin
                        cyc <= cyc + 1'b1;
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // spi strobes run one cycle behind the counter, together with info and cmd
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tick <= '{cs: 1'b1, default: 1'b0};
            info <= '{mode: MODE_CONFIG, frame: '0};
        end else begin
            tick.load <= frame_start;
            tick.cs <= !in_word;
            tick.sclk <= in_word && (phase >= PHASE_W'(BIT_CYCLES / 2));
            tick.shift <= in_word && (phase == '0);
            tick.sample <= in_word && (phase == PHASE_W'(BIT_CYCLES / 2));
            if (frame_start) begin
                info <= '{mode: mode, frame: frame_idx};
            end
        end
    end

    // command for the current frame index
    always_comb begin
        cmd_next = '0;
        tbl_idx = (frame_idx > FRAME_IDX_W'(CLEAR_CAL_FRAME)) ? frame_idx - 1'b1 : frame_idx;
        if (mode == MODE_RECORD) begin
            if (frame_idx < FRAME_IDX_W'(CHANNELS_PER_CHIP)) begin
                cmd_next.conv_cmd.opcode = OP_CONVERT;
                cmd_next.conv_cmd.h = 1'b1;
                cmd_next.conv_cmd.channel = 6'(frame_idx);
            end else begin
                cmd_next.reg_cmd.opcode = OP_READ;      // filler while last results return
                cmd_next.reg_cmd.addr = CHIP_ID_REG;
            end
        end else if (frame_idx == FRAME_IDX_W'(CLEAR_CAL_FRAME)) begin
            cmd_next = CLEAR_CAL_WORD;
        end else if (frame_idx <= FRAME_IDX_W'(CONFIG_WRITES)) begin
            cmd_next.reg_cmd.opcode = OP_WRITE;
            cmd_next.reg_cmd.addr = CONFIG_TABLE[tbl_idx].addr;
            cmd_next.reg_cmd.data = CONFIG_TABLE[tbl_idx].data;
        end else begin
            cmd_next.reg_cmd.opcode = OP_READ;
            cmd_next.reg_cmd.u = 1'b1;                  // trigger the written registers
            cmd_next.reg_cmd.addr = CHIP_ID_REG;
        end
    end

    always_ff @(posedge clk) begin
        if (frame_start) begin
            cmd <= cmd_next;
        end
    end

endmodule

/* verilog/rhs_spi_lane.sv */
`timescale 1ns/10ps

module rhs_spi_lane #(
    parameter int OFFSET_W = 4
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  rhs_array_pkg::spi_tick_t            tick,
    input  rhs_cmd_pkg::rhs_cmd_u               cmd,
    input  logic [OFFSET_W-1:0]                 offset,
    input  logic                                miso,
    output logic                                mosi,
    output logic [rhs_array_pkg::WORD_W-1:0]    rx,
    output logic                                rx_valid
);

    import rhs_array_pkg::*;

    localparam int TAPS = 1 << OFFSET_W;
    localparam int CNT_W = $clog2(WORD_W);

    logic [WORD_W-1:0]  tx_sr;
    logic [TAPS-1:0]    sample_dly;     // tap 0 is one cycle after rising sclk
    logic [CNT_W-1:0]   bit_cnt;
    logic               capture;

    // cable and chip delay differ per lane, so the capture point slides
    assign capture = sample_dly[offset];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mosi <= 1'b0;
            sample_dly <= '0;
            bit_cnt <= '0;
            rx_valid <= 1'b0;
        end else begin
            sample_dly <= {sample_dly[TAPS-2:0], tick.sample};
            rx_valid <= 1'b0;
            if (tick.load) begin
                mosi <= 1'b0;
                bit_cnt <= '0;
            end else if (tick.shift) begin
                mosi <= tx_sr[WORD_W-1];                // msb first
            end
            if (capture) begin
                bit_cnt <= bit_cnt + 1'b1;
                rx_valid <= (bit_cnt == CNT_W'(WORD_W - 1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tick.load) begin
            tx_sr <= cmd;
        end else if (tick.shift) begin
            tx_sr <= {tx_sr[WORD_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rx <= {rx[WORD_W-2:0], miso};
        end
    end

endmodule
